//--- hw/icache_pkg.sv
package icache_pkg;

    // physical byte address and fetched instruction word
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // geometry: 16 sets of 2 ways, 4 words per line
    localparam int line_words = 4;      // also the number of beats in a refill
    localparam int sets = 16;
    localparam int ways = 2;

    // address fields, low to high: byte offset, word offset, index, tag
    localparam int byte_off_w = 2;      // byte within the word, ignored
    localparam int offset_w = 2;
    localparam int index_w = 4;
    localparam int offset_lsb = byte_off_w;
    localparam int index_lsb = offset_lsb + offset_w;
    localparam int tag_lsb = index_lsb + index_w;
    localparam int tag_w = addr_w - tag_lsb;

    // one tag RAM entry, valid on top
    typedef struct packed {
        logic valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // a whole cache line, word 0 in the low bits
    typedef logic [line_words-1:0][word_w-1:0] line_t;

endpackage

//--- hw/icache_ram.sv
module icache_ram #(
    parameter type entry_t = logic,
    parameter int depth = icache_pkg::sets
) (
    input  logic                        clk,
    input  logic                        en,
    input  logic                        we,
    input  logic [icache_pkg::index_w-1:0] addr,
    input  entry_t                      wdata,
    output entry_t                      rdata
);

    entry_t mem [depth];

    // single port, a write returns the old entry on rdata
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/icache_seq_counter.sv
module icache_seq_counter #(
    parameter int width = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic             step,
    output logic [width-1:0] count,
    output logic             last
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;   // wraps back to zero after the last step
        end
    end

    assign last = &count;

    a_clear_step_excl: assert property (@(posedge clk) disable iff (rst) !(clear && step));

endmodule

//--- hw/icache_ctrl.sv
module icache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    input  logic [icache_pkg::addr_w-1:0]  req_addr,
    input  logic                           fence_req,
    input  logic                           hit,
    input  logic                           mem_ar_ready,
    input  logic                           mem_r_valid,
    input  logic                           mem_r_last,
    input  logic                           beat_last,
    input  logic                           set_last,
    output logic                           ready,
    output logic                           resp_valid,
    output logic                           fence_done,
    output logic [icache_pkg::addr_w-1:0]  lookup_addr,
    output logic                           rd_en,
    output logic [icache_pkg::index_w-1:0] rd_index,
    output logic                           fill,
    output logic                           inval,
    output logic [icache_pkg::index_w-1:0] wr_index,
    output logic                           mem_ar_valid,
    output logic [icache_pkg::addr_w-1:0]  mem_ar_addr,
    output logic                           beat_step,
    output logic                           beat_clear,
    output logic                           set_step,
    output logic                           set_clear
);

    typedef enum logic [2:0] {st_idle, st_lookup, st_miss, st_refill, st_fence} state_t;

    state_t state;
    state_t state_next;
    logic   accept;
    logic   fill_q;

    // a hit in LOOKUP keeps the pipe open for the next request
    assign ready  = (state == st_idle) || (state == st_lookup && hit);
    assign accept = req_valid && ready;

    assign rd_en    = accept;   // RAMs are read on the accepting edge
    assign rd_index = req_addr[icache_pkg::index_lsb +: icache_pkg::index_w];

    assign fill     = (state == st_refill) && mem_r_valid && mem_r_last;
    assign inval    = (state == st_fence);
    assign wr_index = lookup_addr[icache_pkg::index_lsb +: icache_pkg::index_w];

    assign resp_valid = (state == st_lookup && hit) || fill_q;

    assign mem_ar_valid = (state == st_miss);
    assign mem_ar_addr  = {lookup_addr[icache_pkg::addr_w-1:icache_pkg::index_lsb],
                           {icache_pkg::index_lsb{1'b0}}};

    assign beat_clear = (state == st_miss);
    assign beat_step  = (state == st_refill) && mem_r_valid;
    assign set_clear  = (state == st_idle) && !req_valid && fence_req;
    assign set_step   = (state == st_fence);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    state_next = st_lookup;
                end else if (fence_req) begin
                    state_next = st_fence;
                end
            end
            st_lookup: begin
                if (!hit) begin
                    state_next = st_miss;
                end else if (!req_valid) begin
                    state_next = st_idle;
                end
            end
            st_miss:   if (mem_ar_ready) state_next = st_refill;
            st_refill: if (fill) state_next = st_idle;
            st_fence:  if (set_last) state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            fill_q     <= 1'b0;
            fence_done <= 1'b0;
        end else begin
            state      <= state_next;
            fill_q     <= fill;   // refill answer goes out the cycle after the line is written
            fence_done <= (state == st_fence) && set_last;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lookup_addr <= req_addr;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar_addr));

    // every beat lands in the line buffer and belongs to the refill in progress
    a_fill_in_refill: assert property (@(posedge clk) disable iff (rst)
        mem_r_valid |-> state == st_refill);

    a_beat_last: assert property (@(posedge clk) disable iff (rst)
        state == st_refill && mem_r_valid |-> beat_last == mem_r_last);

endmodule

//--- hw/icache_tag_store.sv
module icache_tag_store (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rd_en,
    input  logic [icache_pkg::index_w-1:0] rd_index,
    input  logic [icache_pkg::addr_w-1:0]  lookup_addr,
    input  logic                           fill,
    input  logic                           inval,
    input  logic [icache_pkg::index_w-1:0] wr_index,
    output logic                           hit,
    output logic                           hit_way,
    output logic                           fill_way
);

    icache_pkg::tag_entry_t tag_rd [icache_pkg::ways];
    icache_pkg::tag_entry_t tag_wr;

    logic [icache_pkg::ways-1:0]    way_hit;
    logic [icache_pkg::sets-1:0]    lru;       // per set, the way to replace next
    logic [icache_pkg::index_w-1:0] ram_addr;
    logic [icache_pkg::index_w-1:0] lookup_index;
    logic [icache_pkg::tag_w-1:0]   lookup_tag;
    logic                           lookup_q;  // tag_rd holds a fresh read

    assign lookup_index = lookup_addr[icache_pkg::index_lsb +: icache_pkg::index_w];
    assign lookup_tag   = lookup_addr[icache_pkg::tag_lsb +: icache_pkg::tag_w];

    // wr_index is the fence walk position, a fill goes to the looked-up set
    always_comb begin
        if (inval) begin
            ram_addr = wr_index;
        end else if (fill) begin
            ram_addr = lookup_index;
        end else begin
            ram_addr = rd_index;
        end
    end

    assign tag_wr.valid = !inval;
    assign tag_wr.tag   = lookup_tag;

    for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
        icache_ram #(
            .entry_t (icache_pkg::tag_entry_t),
            .depth   (icache_pkg::sets)
        ) tag_ram_i (
            .clk   (clk),
            .en    (rd_en || fill || inval),
            .we    (inval || (fill && fill_way == 1'(w))),
            .addr  (ram_addr),
            .wdata (tag_wr),
            .rdata (tag_rd[w])
        );

        assign way_hit[w] = tag_rd[w].valid && (tag_rd[w].tag == lookup_tag);
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign fill_way = lru[lookup_index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lru      <= '0;
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= rd_en;
            if (fill) begin
                lru[lookup_index] <= ~lru[lookup_index];
            end else if (lookup_q && hit) begin
                lru[lookup_index] <= ~hit_way;   // the other way becomes the victim
            end
        end
    end

    a_fill_inval_excl: assert property (@(posedge clk) disable iff (rst) !(fill && inval));

endmodule

//--- hw/icache_data_store.sv
module icache_data_store (
    input  logic                            clk,
    input  logic                            rd_en,
    input  logic [icache_pkg::index_w-1:0]  rd_index,
    input  logic [icache_pkg::addr_w-1:0]   lookup_addr,
    input  logic                            hit_way,
    input  logic                            fill,
    input  logic                            fill_way,
    input  logic [icache_pkg::index_w-1:0]  wr_index,
    input  logic                            mem_r_valid,
    input  logic [icache_pkg::word_w-1:0]   mem_r_data,
    input  logic [icache_pkg::offset_w-1:0] beat_idx,
    output logic [icache_pkg::word_w-1:0]   resp_data
);

    icache_pkg::line_t line_rd [icache_pkg::ways];
    icache_pkg::line_t fill_buf;
    icache_pkg::line_t fill_line;

    logic [icache_pkg::index_w-1:0]  ram_addr;
    logic [icache_pkg::offset_w-1:0] word_sel;
    logic                            fill_q;

    // collect the beats of the refill
    always_ff @(posedge clk) begin
        if (mem_r_valid) begin
            fill_buf[beat_idx] <= mem_r_data;
        end
        fill_q <= fill;
    end

    // the last beat is still on the bus when the line is written
    always_comb begin
        fill_line = fill_buf;
        fill_line[beat_idx] = mem_r_data;
    end

    assign ram_addr = fill ? wr_index : rd_index;

    for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
        icache_ram #(
            .entry_t (icache_pkg::line_t),
            .depth   (icache_pkg::sets)
        ) data_ram_i (
            .clk   (clk),
            .en    (rd_en || fill),
            .we    (fill && fill_way == 1'(w)),
            .addr  (ram_addr),
            .wdata (fill_line),
            .rdata (line_rd[w])
        );
    end

    assign word_sel = lookup_addr[icache_pkg::offset_lsb +: icache_pkg::offset_w];

    // right after a refill the RAM output is stale, answer from the buffer
    assign resp_data = fill_q ? fill_buf[word_sel] : line_rd[hit_way][word_sel];

endmodule

//--- hw/icache_top.sv
module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [icache_pkg::addr_w-1:0] req_addr,
    output logic                          ready,
    output logic                          resp_valid,
    output logic [icache_pkg::word_w-1:0] resp_data,
    input  logic                          fence_req,
    output logic                          fence_done,
    output logic                          mem_ar_valid,
    output logic [icache_pkg::addr_w-1:0] mem_ar_addr,
    input  logic                          mem_ar_ready,
    input  logic                          mem_r_valid,
    input  logic [icache_pkg::word_w-1:0] mem_r_data,
    input  logic                          mem_r_last
);

    logic [icache_pkg::addr_w-1:0]   lookup_addr;
    logic [icache_pkg::index_w-1:0]  rd_index;
    logic [icache_pkg::index_w-1:0]  wr_index;
    logic [icache_pkg::index_w-1:0]  set_idx;   // fence walk position
    logic [icache_pkg::offset_w-1:0] beat_idx;
    logic rd_en, fill, inval, hit, hit_way, fill_way;
    logic beat_step, beat_clear, beat_last;
    logic set_step, set_clear, set_last;

    icache_ctrl ctrl_i (
        .clk, .rst, .req_valid, .req_addr, .fence_req, .hit,
        .mem_ar_ready, .mem_r_valid, .mem_r_last, .beat_last, .set_last,
        .ready, .resp_valid, .fence_done, .lookup_addr, .rd_en, .rd_index,
        .fill, .inval, .wr_index, .mem_ar_valid, .mem_ar_addr,
        .beat_step, .beat_clear, .set_step, .set_clear
    );

    icache_tag_store tag_store_i (
        .clk, .rst, .rd_en, .rd_index, .lookup_addr, .fill, .inval,
        .wr_index (set_idx),
        .hit, .hit_way, .fill_way
    );

    icache_data_store data_store_i (
        .clk, .rd_en, .rd_index, .lookup_addr, .hit_way, .fill, .fill_way,
        .wr_index, .mem_r_valid, .mem_r_data, .beat_idx, .resp_data
    );

    icache_seq_counter #(.width(icache_pkg::offset_w)) beat_counter (
        .clk, .rst,
        .clear (beat_clear),
        .step  (beat_step),
        .count (beat_idx),
        .last  (beat_last)
    );

    icache_seq_counter #(.width(icache_pkg::index_w)) set_counter (
        .clk, .rst,
        .clear (set_clear),
        .step  (set_step),
        .count (set_idx),
        .last  (set_last)
    );

endmodule

//--- test/icache_mem_model.sv
module icache_mem_model #(
    parameter logic [icache_pkg::word_w-1:0] pattern_key = 32'h5A5A_0000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_ar_valid,
    input  logic [icache_pkg::addr_w-1:0] mem_ar_addr,
    output logic                          mem_ar_ready,
    output logic                          mem_r_valid,
    output logic [icache_pkg::word_w-1:0] mem_r_data,
    output logic                          mem_r_last
);
    timeunit 1ns;
    timeprecision 1ps;

    integer seed;

    // every word of memory holds its own byte address mixed with the key
    initial begin
        int unsigned gap;
        logic [icache_pkg::addr_w-1:0] line_addr;
        seed = 10981;
        mem_ar_ready = 1'b0;
        mem_r_valid = 1'b0;
        mem_r_data = '0;
        mem_r_last = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && mem_ar_valid) begin
                gap = $unsigned($random(seed)) % 4;   // 0 to 3 cycles before the address is taken
                repeat (gap) @(negedge clk);
                line_addr = mem_ar_addr;
                mem_ar_ready = 1'b1;
                @(negedge clk);
                mem_ar_ready = 1'b0;
                for (int beat = 0; beat < icache_pkg::line_words; beat++) begin
                    gap = $unsigned($random(seed)) % 3;
                    repeat (gap) @(negedge clk);
                    mem_r_valid = 1'b1;
                    mem_r_data = (line_addr + 32'(4 * beat)) ^ pattern_key;
                    mem_r_last = (beat == icache_pkg::line_words - 1);
                    @(negedge clk);
                    mem_r_valid = 1'b0;
                    mem_r_last = 1'b0;
                end
            end
        end
    end

endmodule

//--- test/icache_tb.sv
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic {op_read, op_fence} op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic        refill;   // the read is expected to go out to memory
    } step_t;

    localparam logic [31:0] pattern_key = 32'h5A5A_0000;
    localparam int num_steps = 18;
    localparam int timeout_cycles = num_steps * 40 + 200;

    // lines 0x2030, 0x3030 and 0x4030 all map to set 3
    localparam step_t steps [num_steps] = '{
        '{op_read,  32'h0000_1004, 1'b1},   // cold miss
        '{op_read,  32'h0000_1004, 1'b0},
        '{op_read,  32'h0000_1000, 1'b0},   // hits on one line go out on consecutive edges
        '{op_read,  32'h0000_1008, 1'b0},
        '{op_read,  32'h0000_100C, 1'b0},
        '{op_read,  32'h0000_2030, 1'b1},   // fills way 0 of set 3
        '{op_read,  32'h0000_3034, 1'b1},   // fills way 1 of set 3
        '{op_read,  32'h0000_2038, 1'b0},   // 0x3030 becomes the victim
        '{op_read,  32'h0000_403C, 1'b1},   // evicts 0x3030
        '{op_read,  32'h0000_2030, 1'b0},
        '{op_read,  32'h0000_3030, 1'b1},
        '{op_read,  32'h0000_5058, 1'b1},
        '{op_fence, 32'h0000_0000, 1'b0},
        '{op_read,  32'h0000_1004, 1'b1},
        '{op_read,  32'h0000_2030, 1'b1},
        '{op_read,  32'h0000_3030, 1'b1},
        '{op_read,  32'h0000_5058, 1'b1},
        '{op_read,  32'h0000_1000, 1'b0}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        fence_req;
    logic        ready;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        fence_done;
    logic        mem_ar_valid;
    logic [31:0] mem_ar_addr;
    logic        mem_ar_ready;
    logic        mem_r_valid;
    logic [31:0] mem_r_data;
    logic        mem_r_last;

    int          ar_count;
    logic [31:0] ar_addr_seen;
    int          cycle_count = 0;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    icache_top icache_top_i (
        .clk, .rst, .req_valid, .req_addr, .ready, .resp_valid, .resp_data,
        .fence_req, .fence_done, .mem_ar_valid, .mem_ar_addr, .mem_ar_ready,
        .mem_r_valid, .mem_r_data, .mem_r_last
    );

    icache_mem_model #(.pattern_key(pattern_key)) mem_model_i (
        .clk, .rst, .mem_ar_valid, .mem_ar_addr, .mem_ar_ready,
        .mem_r_valid, .mem_r_data, .mem_r_last
    );

    always #5 clk = ~clk;

    // address handshakes as the memory sees them
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_count <= 0;
        end else if (mem_ar_valid && mem_ar_ready) begin
            ar_count <= ar_count + 1;
            ar_addr_seen <= mem_ar_addr;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("error: the run did not finish within %0d cycles", timeout_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ pattern_key;
    endfunction

    task automatic run_read(input logic [31:0] addr, input logic exp_refill);
        int ar_start;
        int wait_cycles;
        ar_start = ar_count;
        while (!ready) @(negedge clk);
        req_valid = 1'b1;
        req_addr = addr;
        @(negedge clk);
        req_valid = 1'b0;
        wait_cycles = 1;
        while (!resp_valid) begin
            @(negedge clk);
            wait_cycles++;
        end
        check_value("resp_data", resp_data, expected_word(addr));
        check_value("ar_handshakes", ar_count - ar_start, exp_refill ? 32'd1 : 32'd0);
        if (exp_refill) begin
            check_value("mem_ar_addr", ar_addr_seen, {addr[31:4], 4'h0});
        end else begin
            check_value("hit_latency", wait_cycles, 32'd1);   // a hit answers in LOOKUP
            check_value("ready", 32'(ready), 32'h1);   // the next request can follow at once
        end
    endtask

    task automatic run_fence();
        int walk;
        @(negedge clk);   // a finished hit drops back to IDLE here
        fence_req = 1'b1;
        @(negedge clk);
        fence_req = 1'b0;
        walk = 1;
        while (!fence_done) begin
            check_value("ready", 32'(ready), 32'h0);
            @(negedge clk);
            walk++;
        end
        check_value("fence_cycles", walk, icache_pkg::sets + 1);
        @(negedge clk);
        check_value("fence_done", 32'(fence_done), 32'h0);
    endtask

    task automatic report_test(input string what, input int errors_before);
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, what);
        end else begin
            $display("test %0d %s: passed", tests_run, what);
        end
    endtask

    initial begin
        int errors_before;
        string what;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        fence_req = 1'b0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        errors_before = error_count;
        check_value("ready", 32'(ready), 32'h1);
        check_value("resp_valid", 32'(resp_valid), 32'h0);
        check_value("fence_done", 32'(fence_done), 32'h0);
        check_value("mem_ar_valid", 32'(mem_ar_valid), 32'h0);
        report_test("reset state", errors_before);

        for (int i = 0; i < num_steps; i++) begin
            errors_before = error_count;
            if (steps[i].op == op_fence) begin
                what = "fence";
                run_fence();
            end else begin
                what = $sformatf("read 0x%08h", steps[i].addr);
                run_read(steps[i].addr, steps[i].refill);
            end
            report_test(what, errors_before);
        end

        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/icache_pkg.sv
hw/icache_ram.sv
hw/icache_seq_counter.sv
hw/icache_ctrl.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

//--- Makefile
TOP = icache_tb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f vlog.f \
		--top-module icache_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
